// File: sources.f
+incdir+hdl
hdl/ahb_mem_pkg.sv
hdl/ahb_req_if.sv
hdl/ahb_addr_phase.sv
hdl/ahb_mem_array.sv
hdl/ahb_resp_gen.sv
hdl/ahb_mem_top.sv
tests/ahb_mem_chk.sv
tests/ahb_mem_tb.sv

// File: Makefile
# Verilator build and run of the AHB-Lite RAM slave testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ahb_mem_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Passes only when the run prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/ahb_mem_tb.sv
// Randomized AHB-Lite master for the RAM slave
// A byte-level reference model predicts read lanes, response timing is
// checked every cycle, hready_i is tied back to hreadyout_o

`include "ahb_mem_settings.svh"

`timescale 1ns/1ps

module ahb_mem_tb
  import ahb_mem_pkg::*;
();

  localparam int CLK_NS    = 10;
  localparam int RST_CYC   = 10;
  localparam int N_XFER    = 500;
  localparam int WS        = `AHB_MEM_WAIT_STATES;
  localparam int LANES     = `AHB_MEM_DATA_W / 8;
  localparam int MEM_BYTES = 1 << `AHB_MEM_ADDR_W;

  // What the slave owes for one data phase
  typedef enum logic [1:0] {DP_NONE, DP_OKAY, DP_ERR} dp_kind_t;

  typedef struct {
    dp_kind_t kind;
    logic     write;
    haddr_t   addr;
    int       size;
    hdata_t   wdata;
  } xfer_t;

  logic    clk_ahb;
  logic    sysrst_n;
  logic    hsel_i;
  haddr_t  haddr_i;
  htrans_t htrans_i;
  logic    hwrite_i;
  hsize_t  hsize_i;
  hdata_t  hwdata_i;
  hdata_t  hrdata_o;
  logic    hreadyout_o;
  logic    hresp_o;

  // Reference memory, bytes never written are skipped
  logic [7:0]  ref_mem [MEM_BYTES];
  logic        ref_vld [MEM_BYTES];
  // Pipeline: address phase on the bus, data phase in progress
  xfer_t       ap;
  xfer_t       dp;
  int          dp_cycle;
  xfer_t       last_wr;
  logic        have_wr;
  logic        ready_seen;
  logic [31:0] rng_state;
  int          issued;
  int          resp_errs;
  int          data_errs;
  int          other_errs;
  int          bytes_checked;

  ahb_mem_top dut (
    .clk_ahb    (clk_ahb),
    .sysrst_n   (sysrst_n),
    .hsel_i     (hsel_i),
    .haddr_i    (haddr_i),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hsize_i    (hsize_i),
    .hwdata_i   (hwdata_i),
    .hready_i   (hreadyout_o),
    .hrdata_o   (hrdata_o),
    .hreadyout_o(hreadyout_o),
    .hresp_o    (hresp_o)
  );

  always #(CLK_NS / 2) clk_ahb = ~clk_ahb;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Pick the next address phase and put it on the bus
  task automatic launch_addr_phase(input logic idle_only);
    logic [31:0] r;
    logic [31:0] pick;
    logic        sel;
    htrans_t     trans;
    xfer_t       x;
    r       = next_rand();
    pick    = next_rand();
    sel     = 1'b1;
    trans   = pick[4] ? SEQ : NONSEQ;
    x.kind  = DP_OKAY;
    x.write = r[31];
    x.wdata = next_rand();
    x.size  = int'(r[9:8]) % 3;
    // Small window so reads hit earlier writes
    x.addr  = haddr_t'((int'(r[5:0]) >> x.size) << x.size);
    if (idle_only || pick[3:0] < 4'd2) begin
      x.kind = DP_NONE;
      case (pick[6:5])
        2'd0:    trans = IDLE;
        2'd1:    trans = BUSY;
        default: sel = 1'b0;
      endcase
      if (idle_only) begin
        trans = IDLE;
      end
    end else if (pick[3:0] < 4'd4) begin
      // Oversized, or halfword/word off its boundary
      x.kind = DP_ERR;
      if (pick[7]) begin
        x.size = 3 + int'(pick[10:8]) % 5;
      end else begin
        x.size    = 1 + int'(pick[8]);
        x.addr[0] = 1'b1;
        x.addr[1] = pick[9];
      end
    end else if (pick[12:11] == 2'd0 && have_wr) begin
      // Read straight back the last legal write
      x.write = 1'b0;
      x.addr  = last_wr.addr;
      x.size  = last_wr.size;
    end
    if (x.kind == DP_OKAY && x.write) begin
      last_wr = x;
      have_wr = 1'b1;
    end
    ap = x;
    hsel_i   <= sel;
    htrans_i <= trans;
    haddr_i  <= x.addr;
    hwrite_i <= x.write;
    hsize_i  <= hsize_t'(3'(x.size));
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic report_bad_response(input string msg);
    $display("FAIL %0t: %s (kind %0d, cycle %0d, hreadyout %b, hresp %b)",
             $time, msg, int'(dp.kind), dp_cycle, hreadyout_o, hresp_o);
    resp_errs++;
  endtask

  // One data-phase cycle, sampled at the falling edge
  task automatic check_cycle();
    haddr_t   a;
    int       lane;
    logic [7:0] got;
    if (dp.kind == DP_NONE) begin
      assert (hreadyout_o && !hresp_o)
      else report_bad_response("idle cycle not zero-wait OKAY");
    end else if (dp.kind == DP_ERR) begin
      assert (hresp_o && (hreadyout_o == (dp_cycle != 0)))
      else report_bad_response("wrong two-cycle ERROR response");
    end else begin
      assert (!hresp_o && (hreadyout_o == (dp_cycle == WS)))
      else report_bad_response("wrong OKAY wait states");
      if (hreadyout_o) begin
        for (int k = 0; k < (1 << dp.size); k++) begin
          a    = dp.addr + haddr_t'(k);
          lane = int'(a) % LANES;
          got  = 8'(hrdata_o >> (8 * lane));
          if (dp.write) begin
            ref_mem[a] = 8'(dp.wdata >> (8 * lane));
            ref_vld[a] = 1'b1;
          end else if (ref_vld[a]) begin
            bytes_checked++;
            assert (got == ref_mem[a]) else begin
              $display("FAIL %0t: read byte %h got %h, expected %h",
                       $time, a, got, ref_mem[a]);
              data_errs++;
            end
          end
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk_ahb   = 1'b0;
    sysrst_n  = 1'b0;
    hsel_i    = 1'b0;
    haddr_i   = '0;
    htrans_i  = IDLE;
    hwrite_i  = 1'b0;
    hsize_i   = BYTE;
    hwdata_i  = '0;
    rng_state = 32'hdf0a;
    ref_vld   = '{default: 1'b0};
    ap.kind   = DP_NONE;
    dp.kind   = DP_NONE;
    have_wr   = 1'b0;
    issued    = 0;
    dp_cycle  = 0;
    resp_errs = 0;
    data_errs = 0;
    other_errs    = 0;
    bytes_checked = 0;
    repeat (RST_CYC) @(posedge clk_ahb);
    sysrst_n <= 1'b1;
    @(negedge clk_ahb);
    assert (hreadyout_o && !hresp_o)
    else report_bad_response("slave not idle OKAY after reset");
    ready_seen = hreadyout_o;
    while (issued < N_XFER || dp.kind != DP_NONE || ap.kind != DP_NONE) begin
      @(posedge clk_ahb);
      if (ready_seen) begin
        // Data phase ends, queued address phase moves in
        dp       = ap;
        dp_cycle = 0;
        if (dp.kind != DP_NONE && dp.write) begin
          hwdata_i <= dp.wdata;
        end
        launch_addr_phase(issued >= N_XFER);
        issued++;
      end else begin
        dp_cycle++;
      end
      @(negedge clk_ahb);
      ready_seen = hreadyout_o;
      check_cycle();
    end
    assert (bytes_checked > 0) else begin
      $display("No read ever returned a previously written byte");
      other_errs++;
    end
    $display("Error counts: response %0d, data %0d, other %0d",
             resp_errs, data_errs, other_errs);
    if (resp_errs + data_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog, worst case per phase is WS + 1 cycles
  initial begin
    #(CLK_NS * (RST_CYC + N_XFER * (WS + 2) + 100));
    $display("Timeout: the transfers did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: tests/ahb_mem_chk.sv
// Response-shape assertions for the AHB-Lite RAM slave
// Bound into every ahb_mem_top instance and watches only HREADYOUT and HRESP

`timescale 1ns/1ps

module ahb_mem_chk (
  input logic clk_ahb,
  input logic sysrst_n,
  input logic hreadyout_i,
  input logic hresp_i
);

  // First ERROR cycle always followed by the second
  err_two_cycle: assert property (
    @(posedge clk_ahb) disable iff (!sysrst_n)
    (hresp_i && !hreadyout_i) |=> (hresp_i && hreadyout_i)
  ) else $error("ERROR response missing its second cycle");

  // ERROR starts with the bus held
  err_starts_low: assert property (
    @(posedge clk_ahb) disable iff (!sysrst_n)
    $rose(hresp_i) |-> !hreadyout_i
  ) else $error("HRESP rose while HREADYOUT was high");

  // Ready straight out of reset
  ready_after_rst: assert property (
    @(posedge clk_ahb)
    $rose(sysrst_n) |-> hreadyout_i
  ) else $error("HREADYOUT low in the first cycle after reset");

endmodule

bind ahb_mem_top ahb_mem_chk u_chk (
  .clk_ahb    (clk_ahb),
  .sysrst_n   (sysrst_n),
  .hreadyout_i(hreadyout_o),
  .hresp_i    (hresp_o)
);

// File: hdl/ahb_mem_top.sv
// AHB-Lite single-port RAM slave, top level
// Plain bus ports; a single slave gets hready_i tied to hreadyout_o

`timescale 1ns/1ps

module ahb_mem_top
  import ahb_mem_pkg::*;
(
  input  logic    clk_ahb,
  input  logic    sysrst_n,
  input  logic    hsel_i,
  input  haddr_t  haddr_i,
  input  htrans_t htrans_i,
  input  logic    hwrite_i,
  input  hsize_t  hsize_i,
  input  hdata_t  hwdata_i,
  input  logic    hready_i,
  output hdata_t  hrdata_o,
  output logic    hreadyout_o,
  output logic    hresp_o
);

  // Captured request shared by the three blocks
  ahb_req_if req_bus ();

  // Last cycle of a legal data phase
  logic commit;

  // Address phase in
  ahb_addr_phase u_addr_phase (
    .clk_ahb (clk_ahb),
    .sysrst_n(sysrst_n),
    .hsel_i  (hsel_i),
    .haddr_i (haddr_i),
    .htrans_i(htrans_i),
    .hwrite_i(hwrite_i),
    .hsize_i (hsize_i),
    .hready_i(hready_i),
    .req_o   (req_bus.src)
  );

  // Wait states and ERROR
  ahb_resp_gen u_resp_gen (
    .clk_ahb    (clk_ahb),
    .sysrst_n   (sysrst_n),
    .req_i      (req_bus.rsp),
    .hreadyout_o(hreadyout_o),
    .hresp_o    (hresp_o),
    .commit_o   (commit)
  );

  // Storage
  ahb_mem_array u_mem_array (
    .clk_ahb (clk_ahb),
    .req_i   (req_bus.mem),
    .commit_i(commit),
    .hwdata_i(hwdata_i),
    .hrdata_o(hrdata_o)
  );

endmodule

// File: hdl/ahb_resp_gen.sv
// Response shaping of the AHB-Lite RAM slave
// Counts wait states off the captured request and drives HREADYOUT/HRESP,
// commit marks the final cycle of a legal data phase for the storage

`include "ahb_mem_settings.svh"

`timescale 1ns/1ps

module ahb_resp_gen (
  input  logic   clk_ahb,
  input  logic   sysrst_n,
  ahb_req_if.rsp req_i,
  output logic   hreadyout_o,
  output logic   hresp_o,
  output logic   commit_o
);

  localparam int WAIT_STATES = `AHB_MEM_WAIT_STATES;
  // Counter holds WAIT_STATES-1 at most
  localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'((WAIT_STATES > 0) ? WAIT_STATES - 1 : 0);

  // READY also covers the first cycle of every data phase,
  // which is decoded straight from the request
  typedef enum logic [1:0] {
    ST_READY,
    ST_WAIT,
    ST_ERR
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    // Default is zero-wait OKAY
    hreadyout_o = 1'b1;
    hresp_o     = 1'b0;
    commit_o    = 1'b0;
    case (state_q)
      ST_READY: begin
        if (req_i.valid) begin
          if (req_i.err) begin
            // First ERROR cycle, bus held
            hreadyout_o = 1'b0;
            hresp_o     = 1'b1;
            state_d     = ST_ERR;
          end else if (WAIT_STATES == 0) begin
            commit_o = 1'b1;
          end else begin
            // First wait state
            hreadyout_o = 1'b0;
            cnt_d       = CNT_LOAD;
            state_d     = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        if (cnt_q == '0) begin
          // Ready cycle, read data out and write data in
          commit_o = 1'b1;
          state_d  = ST_READY;
        end else begin
          hreadyout_o = 1'b0;
          cnt_d       = cnt_q - 1'b1;
        end
      end
      ST_ERR: begin
        // Second ERROR cycle releases the bus
        hresp_o = 1'b1;
        state_d = ST_READY;
      end
      default: state_d = ST_READY;
    endcase
  end

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_ahb or negedge sysrst_n) begin
    if (!sysrst_n) begin
      state_q <= ST_READY;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// File: hdl/ahb_mem_array.sv
// Storage of the AHB-Lite RAM slave
// Little-endian byte lanes, combinational read of the addressed word,
// lane-masked write on the edge that closes a legal write data phase

`include "ahb_mem_settings.svh"

`timescale 1ns/1ps

module ahb_mem_array
  import ahb_mem_pkg::*;
(
  input  logic   clk_ahb,
  ahb_req_if.mem req_i,
  input  logic   commit_i,
  input  hdata_t hwdata_i,
  output hdata_t hrdata_o
);

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  // Bytes per bus word
  localparam int LANES = `AHB_MEM_DATA_W / 8;
  // Address bits that pick a lane
  localparam int OFF_W = $clog2(LANES);
  // Address bits that pick a word
  localparam int IDX_W = `AHB_MEM_ADDR_W - OFF_W;
  localparam int DEPTH = 2 ** IDX_W;

  // Word storage
  hdata_t           mem_q [DEPTH];

  logic [IDX_W-1:0] word_idx;
  logic [OFF_W-1:0] lane_off;
  logic [LANES-1:0] lane_en;
  logic             wr_en;

  //////////////////////////////////////////////////
  // Lane decode
  //////////////////////////////////////////////////

  // Lanes touched by an aligned access of 2**size bytes
  // A lane is in when it sits in the same size-block as the offset
  function automatic logic [LANES-1:0] lane_mask(
    input hsize_t           size,
    input logic [OFF_W-1:0] off
  );
    logic [LANES-1:0] mask;
    int               shift;
    mask  = '0;
    shift = int'(size);
    for (int i = 0; i < LANES; i++) begin
      mask[i] = ((i >> shift) == (int'(off) >> shift));
    end
    return mask;
  endfunction

  assign word_idx = req_i.addr[`AHB_MEM_ADDR_W-1:OFF_W];
  assign lane_off = req_i.addr[OFF_W-1:0];
  assign lane_en  = lane_mask(req_i.size, lane_off);

  // Commit only comes for legal transfers
  assign wr_en = commit_i && req_i.write;

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // HWDATA is valid in the ready cycle, so it is
  // taken on the edge that closes the data phase
  always_ff @(posedge clk_ahb) begin
    if (wr_en) begin
      for (int i = 0; i < LANES; i++) begin
        if (lane_en[i]) begin
          mem_q[word_idx][i*8 +: 8] <= hwdata_i[i*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Whole word out, master keeps the lanes it asked for
  // A write committed on the previous edge is already visible here
  assign hrdata_o = mem_q[word_idx];

endmodule

// File: hdl/ahb_addr_phase.sv
// Address-phase capture of the AHB-Lite RAM slave
// Samples HSEL/HTRANS/HADDR/HSIZE/HWRITE while HREADY is high and flags
// illegal transfers, the result drives the data phase of the other blocks

`timescale 1ns/1ps

module ahb_addr_phase
  import ahb_mem_pkg::*;
(
  input  logic    clk_ahb,
  input  logic    sysrst_n,
  input  logic    hsel_i,
  input  haddr_t  haddr_i,
  input  htrans_t htrans_i,
  input  logic    hwrite_i,
  input  hsize_t  hsize_i,
  input  logic    hready_i,
  ahb_req_if.src  req_o
);

  // Selected and NONSEQ/SEQ
  logic open_xfer;
  // Size wider than one bus word
  logic size_bad;
  // Low address bits not on a size boundary
  logic misaligned;

  //////////////////////////////////////////////////
  // Legality decode
  //////////////////////////////////////////////////

  // IDLE and BUSY never open a data phase
  assign open_xfer = hsel_i && ((htrans_i == NONSEQ) || (htrans_i == SEQ));

  assign size_bad = (hsize_i > WORD);

  always_comb begin
    case (hsize_i)
      HALF:    misaligned = haddr_i[0];
      WORD:    misaligned = |haddr_i[1:0];
      // Bytes are always aligned, oversize caught above
      default: misaligned = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Request registers
  //////////////////////////////////////////////////

  // Status, updated on every accepted address phase
  always_ff @(posedge clk_ahb or negedge sysrst_n) begin
    if (!sysrst_n) begin
      req_o.valid <= 1'b0;
      req_o.err   <= 1'b0;
    end else if (hready_i) begin
      req_o.valid <= open_xfer;
      req_o.err   <= open_xfer && (size_bad || misaligned);
    end
  end

  // Access fields only move when a transfer opens
  // Held through wait states and while HREADY is low
  always_ff @(posedge clk_ahb) begin
    if (hready_i && open_xfer) begin
      req_o.write <= hwrite_i;
      req_o.addr  <= haddr_i;
      req_o.size  <= hsize_i;
    end
  end

endmodule

// File: hdl/ahb_req_if.sv
// Captured address-phase request of the AHB-Lite RAM slave
// Written by the address-phase block, read by the response and storage blocks

`timescale 1ns/1ps

interface ahb_req_if
  import ahb_mem_pkg::*;
();

  // Data phase in progress
  logic   valid;
  // Request refused, answer with ERROR
  logic   err;
  // Direction, high for a write
  logic   write;
  // Byte address and transfer size
  haddr_t addr;
  hsize_t size;

  // Address-phase register side
  modport src (
    output valid,
    output err,
    output write,
    output addr,
    output size
  );

  // Response shaping only needs status
  modport rsp (input valid, input err);

  // Storage only needs the access itself
  modport mem (input write, input addr, input size);

endinterface

// File: hdl/ahb_mem_pkg.sv
// Bus field types for the AHB-Lite RAM slave
// Imported by every RTL block and by the testbench

`include "ahb_mem_settings.svh"

package ahb_mem_pkg;

  //////////////////////////////////////////////////
  // AHB-Lite control encodings
  //////////////////////////////////////////////////

  // HTRANS, only NONSEQ and SEQ open a transfer
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE, anything above WORD is refused by this RAM
  typedef enum logic [2:0] {
    BYTE   = 3'b000,
    HALF   = 3'b001,
    WORD   = 3'b010,
    DWORD  = 3'b011,
    LINE4  = 3'b100,
    LINE8  = 3'b101,
    LINE16 = 3'b110,
    LINE32 = 3'b111
  } hsize_t;

  //////////////////////////////////////////////////
  // Address and data
  //////////////////////////////////////////////////

  // Byte address inside the RAM window
  typedef logic [`AHB_MEM_ADDR_W-1:0] haddr_t;

  // One bus word
  typedef logic [`AHB_MEM_DATA_W-1:0] hdata_t;

endpackage

// File: hdl/ahb_mem_settings.svh
// Build-time sizing of the AHB-Lite RAM slave
// Included by the package and by RTL that needs raw widths or timing

`ifndef AHB_MEM_SETTINGS_SVH
`define AHB_MEM_SETTINGS_SVH

//////////////////////////////////////////////////
// Bus and memory geometry
//////////////////////////////////////////////////

// HWDATA / HRDATA width in bits
`define AHB_MEM_DATA_W 32

// Byte address bits decoded by the memory (1 KB)
// Upper HADDR bits are dropped, so the RAM aliases
`define AHB_MEM_ADDR_W 10

//////////////////////////////////////////////////
// Response timing
//////////////////////////////////////////////////

// Cycles of HREADYOUT low per legal transfer
`define AHB_MEM_WAIT_STATES 3

`endif
